// ==== rtl/rbz_pkg.sv ====
`default_nettype none

package rbz_pkg;

    localparam int RGB_W   = 6;     // BBGGRR
    localparam int POS_W   = 10;    // Raster counter width
    localparam int FRAME_W = 16;    // Bits per serial register frame

    localparam logic [3:0] ADDR_COLORS = 4'd1;  // Sky and floor colours
    localparam logic [3:0] ADDR_CTRL   = 4'd2;  // Horizon row and overlay

    // One received frame, read either as a colour write or a control write
    typedef union packed {
        struct packed {
            logic [3:0]       addr;
            logic [RGB_W-1:0] sky;
            logic [RGB_W-1:0] floor;
        } colors;
        struct packed {
            logic [3:0]       addr;
            logic [POS_W-1:0] horizon;
            logic             overlay_en;
            logic             spare;    // Unused
        } ctrl;
    } reg_frame_u;

    // Debug output sources, code 0 is per channel
    typedef enum logic [3:0] {
        GP_PRIMARY  = 4'd0,  GP_FRAME    = 4'd1,  GP_CLK_DIV2 = 4'd2,  GP_CLK_DIV4 = 4'd3,
        GP_HPOS0    = 4'd4,  GP_HPOS1    = 4'd5,  GP_HPOS8    = 4'd6,  GP_HPOS9    = 4'd7,
        GP_VPOS0    = 4'd8,  GP_VPOS1    = 4'd9,  GP_VPOS8    = 4'd10, GP_VPOS9    = 4'd11,
        GP_CSB      = 4'd12, GP_MOSI     = 4'd13, GP_HSYNC    = 4'd14, GP_VSYNC    = 4'd15
    } gpout_sel_t;

endpackage

`default_nettype wire

// ==== rtl/reg_spi_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_spi_rx (
    input  wire                          clk,
    input  wire                          rbzero_reset,
    input  wire                          i_csb,          // Active low chip select
    input  wire                          i_sclk,
    input  wire                          i_mosi,
    output logic [rbz_pkg::RGB_W-1:0]    o_sky,
    output logic [rbz_pkg::RGB_W-1:0]    o_floor,
    output logic [rbz_pkg::POS_W-1:0]    o_horizon,
    output logic                         o_overlay_en,
    output logic                         o_frame_pulse,  // One clk per accepted frame
    output logic                         o_csb_s,
    output logic                         o_mosi_s
);

    localparam int         FW       = rbz_pkg::FRAME_W;
    localparam logic [4:0] CNT_FULL = 5'(FW);
    localparam logic [4:0] CNT_OVER = 5'(FW + 1);  // Saturates here on long frames

    logic [1:0]         csb_sync;   // Two-flop synchronisers
    logic [1:0]         sclk_sync;
    logic [1:0]         mosi_sync;
    logic               csb_q;      // Previous synchronised values for edge detect
    logic               sclk_q;
    logic               sclk_rise;
    logic               csb_rise;
    logic [4:0]         bit_cnt;
    logic [FW-1:0]      shift_q;
    logic               frame_ok;
    rbz_pkg::reg_frame_u rx_frame;

    assign o_csb_s   = csb_sync[1];
    assign o_mosi_s  = mosi_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_q;
    assign csb_rise  = csb_sync[1] & ~csb_q;
    assign frame_ok  = csb_rise && (bit_cnt == CNT_FULL);   // Exactly 16 bits
    assign rx_frame  = shift_q;

    always_ff @(posedge clk) begin
        if (rbzero_reset) begin
            csb_sync  <= 2'b11;     // Idle is deselected
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            csb_q     <= 1'b1;
            sclk_q    <= 1'b0;
        end else begin
            csb_sync  <= {csb_sync[0], i_csb};
            sclk_sync <= {sclk_sync[0], i_sclk};
            mosi_sync <= {mosi_sync[0], i_mosi};
            csb_q     <= csb_sync[1];
            sclk_q    <= sclk_sync[1];
        end
    end

    // Bit count restarts whenever the chip is deselected
    always_ff @(posedge clk) begin
        if (rbzero_reset || o_csb_s) bit_cnt <= '0;
        else if (sclk_rise && bit_cnt != CNT_OVER) bit_cnt <= bit_cnt + 5'd1;
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (!o_csb_s && sclk_rise) shift_q <= {shift_q[FW-2:0], o_mosi_s};
    end

    always_ff @(posedge clk) begin
        if (rbzero_reset) begin
            o_sky         <= '0;
            o_floor       <= '0;
            o_horizon     <= '0;
            o_overlay_en  <= 1'b0;
            o_frame_pulse <= 1'b0;
        end else begin
            o_frame_pulse <= 1'b0;
            if (frame_ok && rx_frame.colors.addr == rbz_pkg::ADDR_COLORS) begin
                o_sky         <= rx_frame.colors.sky;
                o_floor       <= rx_frame.colors.floor;
                o_frame_pulse <= 1'b1;
            end else if (frame_ok && rx_frame.ctrl.addr == rbz_pkg::ADDR_CTRL) begin
                o_horizon     <= rx_frame.ctrl.horizon;
                o_overlay_en  <= rx_frame.ctrl.overlay_en;
                o_frame_pulse <= 1'b1;
            end     // Other addresses dropped
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vga_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_sync #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire                          clk,
    input  wire                          rbzero_reset,
    output logic [rbz_pkg::POS_W-1:0]    o_hpos,
    output logic [rbz_pkg::POS_W-1:0]    o_vpos,
    output logic                         o_hsync_n,
    output logic                         o_vsync_n,
    output logic                         o_hblank,
    output logic                         o_vblank
);

    localparam int PW = rbz_pkg::POS_W;

    localparam logic [PW-1:0] H_LAST = PW'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [PW-1:0] H_ACT  = PW'(H_ACTIVE);
    localparam logic [PW-1:0] HS_BEG = PW'(H_ACTIVE + H_FRONT);
    localparam logic [PW-1:0] HS_END = PW'(H_ACTIVE + H_FRONT + H_SYNC);   // First count past sync
    localparam logic [PW-1:0] V_LAST = PW'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam logic [PW-1:0] V_ACT  = PW'(V_ACTIVE);
    localparam logic [PW-1:0] VS_BEG = PW'(V_ACTIVE + V_FRONT);
    localparam logic [PW-1:0] VS_END = PW'(V_ACTIVE + V_FRONT + V_SYNC);

    logic          h_wrap;
    logic [PW-1:0] h_nxt;
    logic [PW-1:0] v_nxt;

    assign h_wrap = (o_hpos == H_LAST);
    assign h_nxt  = h_wrap ? '0 : o_hpos + 1'b1;
    assign v_nxt  = !h_wrap ? o_vpos :
                    (o_vpos == V_LAST) ? '0 : o_vpos + 1'b1;   // Steps once per line

    // Flags come from next counts so they line up with the counters
    always_ff @(posedge clk) begin
        if (rbzero_reset) begin
            o_hpos    <= '0;
            o_vpos    <= '0;
            o_hsync_n <= 1'b1;  // Position 0 is active video
            o_vsync_n <= 1'b1;
            o_hblank  <= 1'b0;
            o_vblank  <= 1'b0;
        end else begin
            o_hpos    <= h_nxt;
            o_vpos    <= v_nxt;
            o_hsync_n <= !(h_nxt >= HS_BEG && h_nxt < HS_END);
            o_vsync_n <= !(v_nxt >= VS_BEG && v_nxt < VS_END);
            o_hblank  <= (h_nxt >= H_ACT);
            o_vblank  <= (v_nxt >= V_ACT);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/row_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_render (
    input  wire                          i_hblank,
    input  wire                          i_vblank,
    input  wire [rbz_pkg::POS_W-1:0]     i_vpos,
    input  wire [rbz_pkg::RGB_W-1:0]     i_sky,
    input  wire [rbz_pkg::RGB_W-1:0]     i_floor,
    input  wire [rbz_pkg::POS_W-1:0]     i_horizon,    // First floor row
    input  wire                          i_overlay_en, // Draw horizon line in white
    output logic [rbz_pkg::RGB_W-1:0]    o_rgb         // BBGGRR
);

    localparam logic [rbz_pkg::RGB_W-1:0] RGB_BLACK = '0;
    localparam logic [rbz_pkg::RGB_W-1:0] RGB_WHITE = '1;

    logic blank;
    logic on_horizon;
    logic above;

    assign blank      = i_hblank | i_vblank;
    assign on_horizon = i_overlay_en && (i_vpos == i_horizon);
    assign above      = (i_vpos < i_horizon);  // Horizon beyond screen gives all sky

    // Priority as listed, blanking wins
    always_comb begin
        if (blank) begin
            o_rgb = RGB_BLACK;
        end else if (on_horizon) begin
            o_rgb = RGB_WHITE;
        end else if (above) begin
            o_rgb = i_sky;
        end else begin
            o_rgb = i_floor;   // Horizon 0 means floor everywhere
        end
    end

endmodule

`default_nettype wire

// ==== rtl/gpout_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpout_bank (
    input  wire                          clk,
    input  wire                          rbzero_reset,
    input  wire rbz_pkg::gpout_sel_t     i_sel0,
    input  wire rbz_pkg::gpout_sel_t     i_sel1,
    input  wire rbz_pkg::gpout_sel_t     i_sel2,
    input  wire                          i_hblank,
    input  wire                          i_vblank,
    input  wire [rbz_pkg::POS_W-1:0]     i_hpos,
    input  wire [rbz_pkg::POS_W-1:0]     i_vpos,
    input  wire                          i_hsync_n,
    input  wire                          i_vsync_n,
    input  wire                          i_frame_pulse,
    input  wire                          i_csb_s,
    input  wire                          i_mosi_s,
    output logic [2:0]                   o_gpout
);

    logic [1:0]          clk_div;    // Free-running from reset
    logic [2:0]          primary;    // Code 0 source of each channel
    rbz_pkg::gpout_sel_t sel [3];

    assign primary = {i_hpos[2], i_vblank, i_hblank};
    assign sel[0]  = i_sel0;
    assign sel[1]  = i_sel1;
    assign sel[2]  = i_sel2;

    always_ff @(posedge clk) begin
        if (rbzero_reset) clk_div <= 2'd0;
        else clk_div <= clk_div + 2'd1;
    end

    // Same 16-way table for each channel
    for (genvar ch = 0; ch < 3; ch++) begin : g_chan
        always_comb begin
            case (sel[ch])
                rbz_pkg::GP_PRIMARY:  o_gpout[ch] = primary[ch];
                rbz_pkg::GP_FRAME:    o_gpout[ch] = i_frame_pulse;
                rbz_pkg::GP_CLK_DIV2: o_gpout[ch] = clk_div[0];
                rbz_pkg::GP_CLK_DIV4: o_gpout[ch] = clk_div[1];
                rbz_pkg::GP_HPOS0:    o_gpout[ch] = i_hpos[0];
                rbz_pkg::GP_HPOS1:    o_gpout[ch] = i_hpos[1];
                rbz_pkg::GP_HPOS8:    o_gpout[ch] = i_hpos[8];
                rbz_pkg::GP_HPOS9:    o_gpout[ch] = i_hpos[9];
                rbz_pkg::GP_VPOS0:    o_gpout[ch] = i_vpos[0];
                rbz_pkg::GP_VPOS1:    o_gpout[ch] = i_vpos[1];
                rbz_pkg::GP_VPOS8:    o_gpout[ch] = i_vpos[8];
                rbz_pkg::GP_VPOS9:    o_gpout[ch] = i_vpos[9];
                rbz_pkg::GP_CSB:      o_gpout[ch] = i_csb_s;
                rbz_pkg::GP_MOSI:     o_gpout[ch] = i_mosi_s;
                rbz_pkg::GP_HSYNC:    o_gpout[ch] = i_hsync_n;  // Raw, before output stage
                rbz_pkg::GP_VSYNC:    o_gpout[ch] = i_vsync_n;
                default:              o_gpout[ch] = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vga_out_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_out_stage (
    input  wire                          clk,
    input  wire                          rbzero_reset,
    input  wire                          i_reg_outs_enb,  // 0 registered, 1 direct
    input  wire [rbz_pkg::RGB_W-1:0]     i_rgb,
    input  wire                          i_hsync_n,
    input  wire                          i_vsync_n,
    input  wire [2:0]                    i_gpout,
    output logic [rbz_pkg::RGB_W-1:0]    o_rgb,
    output logic                         o_hsync,
    output logic                         o_vsync,
    output logic [2:0]                   o_gpout
);

    logic [rbz_pkg::RGB_W-1:0] rgb_q;     // One clock behind the raw signals
    logic                      hsync_q;
    logic                      vsync_q;
    logic [2:0]                gpout_q;

    always_ff @(posedge clk) begin
        if (rbzero_reset) begin
            rgb_q   <= '0;
            hsync_q <= 1'b1;  // Syncs idle high
            vsync_q <= 1'b1;
            gpout_q <= '0;
        end else begin
            rgb_q   <= i_rgb;
            hsync_q <= i_hsync_n;
            vsync_q <= i_vsync_n;
            gpout_q <= i_gpout;
        end
    end

    assign o_rgb   = i_reg_outs_enb ? i_rgb     : rgb_q;
    assign o_hsync = i_reg_outs_enb ? i_hsync_n : hsync_q;
    assign o_vsync = i_reg_outs_enb ? i_vsync_n : vsync_q;
    assign o_gpout = i_reg_outs_enb ? i_gpout   : gpout_q;

endmodule

`default_nettype wire

// ==== rtl/rbz_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_top #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire                          clk,
    input  wire                          rbzero_reset,
    input  wire                          i_reg_csb,       // Register port, active low
    input  wire                          i_reg_sclk,      // At most clk/8
    input  wire                          i_reg_mosi,
    input  wire                          i_reg_outs_enb,  // 0 registered, 1 direct
    input  wire [3:0]                    i_gpout0_sel,
    input  wire [3:0]                    i_gpout1_sel,
    input  wire [3:0]                    i_gpout2_sel,
    output wire                          o_hsync,
    output wire                          o_vsync,
    output wire [rbz_pkg::RGB_W-1:0]     o_rgb,           // BBGGRR
    output wire [2:0]                    o_gpout
);

    logic [rbz_pkg::RGB_W-1:0] sky, floor, rgb;
    logic [rbz_pkg::POS_W-1:0] horizon, hpos, vpos;
    logic                      overlay_en, frame_pulse, csb_s, mosi_s;
    logic                      hsync_n, vsync_n, hblank, vblank;
    logic [2:0]                gpout;   // Unregistered debug bits

    reg_spi_rx spi_i (
        .clk(clk), .rbzero_reset(rbzero_reset),
        .i_csb(i_reg_csb), .i_sclk(i_reg_sclk), .i_mosi(i_reg_mosi),
        .o_sky(sky), .o_floor(floor), .o_horizon(horizon), .o_overlay_en(overlay_en),
        .o_frame_pulse(frame_pulse), .o_csb_s(csb_s), .o_mosi_s(mosi_s)
    );

    vga_sync #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) sync_i (
        .clk(clk), .rbzero_reset(rbzero_reset),
        .o_hpos(hpos), .o_vpos(vpos), .o_hsync_n(hsync_n), .o_vsync_n(vsync_n),
        .o_hblank(hblank), .o_vblank(vblank)
    );

    row_render render_i (
        .i_hblank(hblank), .i_vblank(vblank), .i_vpos(vpos),
        .i_sky(sky), .i_floor(floor), .i_horizon(horizon), .i_overlay_en(overlay_en),
        .o_rgb(rgb)
    );

    gpout_bank gpout_i (
        .clk(clk), .rbzero_reset(rbzero_reset),
        .i_sel0(rbz_pkg::gpout_sel_t'(i_gpout0_sel)),   // Select pins as debug codes
        .i_sel1(rbz_pkg::gpout_sel_t'(i_gpout1_sel)),
        .i_sel2(rbz_pkg::gpout_sel_t'(i_gpout2_sel)),
        .i_hblank(hblank), .i_vblank(vblank), .i_hpos(hpos), .i_vpos(vpos),
        .i_hsync_n(hsync_n), .i_vsync_n(vsync_n),
        .i_frame_pulse(frame_pulse), .i_csb_s(csb_s), .i_mosi_s(mosi_s),
        .o_gpout(gpout)
    );

    vga_out_stage out_i (
        .clk(clk), .rbzero_reset(rbzero_reset), .i_reg_outs_enb(i_reg_outs_enb),
        .i_rgb(rgb), .i_hsync_n(hsync_n), .i_vsync_n(vsync_n), .i_gpout(gpout),
        .o_rgb(o_rgb), .o_hsync(o_hsync), .o_vsync(o_vsync), .o_gpout(o_gpout)
    );

endmodule

`default_nettype wire

// ==== bench/rbz_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_assertions #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48
) (
    input wire                      clk,
    input wire                      rbzero_reset,
    input wire [rbz_pkg::POS_W-1:0] i_hpos,
    input wire [rbz_pkg::POS_W-1:0] i_vpos,
    input wire                      i_hsync_n    // Active low
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int HS_BEG  = H_ACTIVE + H_FRONT;    // Sync window start
    localparam int HS_END  = HS_BEG + H_SYNC;       // First count past it

    hpos_in_line: assert property (@(posedge clk) disable iff (rbzero_reset)
        int'(i_hpos) < H_TOTAL)
        else $error("hpos %0d at or past the line total", i_hpos);

    hsync_in_window: assert property (@(posedge clk) disable iff (rbzero_reset)
        !i_hsync_n |-> (int'(i_hpos) >= HS_BEG && int'(i_hpos) < HS_END))
        else $error("hsync low outside the sync window at hpos %0d", i_hpos);

    // Row only advances on the wrap back to column 0
    vpos_on_wrap: assert property (@(posedge clk) disable iff (rbzero_reset)
        i_vpos != $past(i_vpos) |-> i_hpos == '0)
        else $error("vpos moved while hpos is %0d", i_hpos);

endmodule

`default_nettype wire

// ==== bench/rbz_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rbz_tb;

    localparam int HA = 16;     // Small raster of 24 x 17 clocks per frame
    localparam int HF = 2;
    localparam int HS = 3;
    localparam int HB = 3;
    localparam int VA = 12;
    localparam int VF = 1;
    localparam int VS = 2;
    localparam int VB = 2;
    localparam int H_TOT = HA + HF + HS + HB;
    localparam int V_TOT = VA + VF + VS + VB;
    localparam int WAIT_LIMIT = 2 * H_TOT * V_TOT;

    logic       clk, rbzero_reset;
    logic       i_reg_csb, i_reg_sclk, i_reg_mosi, i_reg_outs_enb;
    logic [3:0] i_gpout0_sel, i_gpout1_sel, i_gpout2_sel;
    wire        o_hsync, o_vsync;
    wire  [5:0] o_rgb;
    wire  [2:0] o_gpout;

    integer     seed;
    int         m_h, m_v, m_hor;             // Model raster position and horizon row
    logic [1:0] m_div, csb_pipe, mosi_pipe;  // Divider and pin synchronisers
    logic [5:0] m_sky, m_floor, q_rgb;
    logic       m_ov, q_hs, q_vs;
    logic [2:0] q_gp;                        // q_ values lag the direct model by one clock
    bit         chk_on, chk_gp, count_pulse;
    int         errors, checks, pulse_cnt;
    string      test_name;

    rbz_top #(
        .H_ACTIVE(HA), .H_FRONT(HF), .H_SYNC(HS), .H_BACK(HB),
        .V_ACTIVE(VA), .V_FRONT(VF), .V_SYNC(VS), .V_BACK(VB)
    ) dut_i (
        .clk(clk), .rbzero_reset(rbzero_reset),
        .i_reg_csb(i_reg_csb), .i_reg_sclk(i_reg_sclk), .i_reg_mosi(i_reg_mosi),
        .i_reg_outs_enb(i_reg_outs_enb), .i_gpout0_sel(i_gpout0_sel),
        .i_gpout1_sel(i_gpout1_sel), .i_gpout2_sel(i_gpout2_sel),
        .o_hsync(o_hsync), .o_vsync(o_vsync), .o_rgb(o_rgb), .o_gpout(o_gpout)
    );

    bind vga_sync rbz_assertions #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK)
    ) sva_i (
        .clk(clk), .rbzero_reset(rbzero_reset),
        .i_hpos(o_hpos), .i_vpos(o_vpos), .i_hsync_n(o_hsync_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic exp_hsync(int h);
        return !(h >= HA + HF && h < HA + HF + HS);
    endfunction

    function automatic logic exp_vsync(int v);
        return !(v >= VA + VF && v < VA + VF + VS);
    endfunction

    function automatic logic [5:0] exp_rgb(int h, int v);
        if (h >= HA || v >= VA) return 6'h00;   // Blanking
        if (m_ov && v == m_hor) return 6'h3f;   // White horizon line
        if (v < m_hor) return m_sky;
        return m_floor;
    endfunction

    function automatic logic gp_source(int ch, logic [3:0] sel, int h, int v);
        logic [15:0] src;
        logic        prim;
        prim = (ch == 0) ? (h >= HA) : (ch == 1) ? (v >= VA) : h[2];
        src  = {exp_vsync(v), exp_hsync(h), mosi_pipe[1], csb_pipe[1],
                v[9], v[8], v[1], v[0], h[9], h[8], h[1], h[0],
                m_div[1], m_div[0], 1'b0, prim};    // Bit index is the select code
        return src[sel];                            // Frame pulse low between frames
    endfunction

    function automatic logic [2:0] exp_gpout(int h, int v);
        return {gp_source(2, i_gpout2_sel, h, v), gp_source(1, i_gpout1_sel, h, v),
                gp_source(0, i_gpout0_sel, h, v)};
    endfunction

    // Reference raster counting from reset like the DUT
    always @(posedge clk) begin
        csb_pipe  <= {csb_pipe[0], i_reg_csb};
        mosi_pipe <= {mosi_pipe[0], i_reg_mosi};
        if (rbzero_reset) begin
            m_h   <= 0;
            m_v   <= 0;
            m_div <= 2'd0;
            q_rgb <= 6'd0;
            q_hs  <= 1'b1;  // Registered syncs idle high
            q_vs  <= 1'b1;
            q_gp  <= 3'd0;
        end else begin
            m_h   <= (m_h == H_TOT - 1) ? 0 : m_h + 1;
            if (m_h == H_TOT - 1) m_v <= (m_v == V_TOT - 1) ? 0 : m_v + 1;
            m_div <= m_div + 2'd1;
            q_rgb <= exp_rgb(m_h, m_v);
            q_hs  <= exp_hsync(m_h);
            q_vs  <= exp_vsync(m_v);
            q_gp  <= exp_gpout(m_h, m_v);
        end
    end

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // Outputs are sampled mid-cycle well away from the drive edge
    always @(negedge clk) begin : compare_outputs
        logic [5:0] e_rgb;
        logic [2:0] e_gp;
        logic       e_hs;
        logic       e_vs;
        e_rgb = i_reg_outs_enb ? exp_rgb(m_h, m_v) : q_rgb;
        e_hs  = i_reg_outs_enb ? exp_hsync(m_h) : q_hs;
        e_vs  = i_reg_outs_enb ? exp_vsync(m_v) : q_vs;
        e_gp  = i_reg_outs_enb ? exp_gpout(m_h, m_v) : q_gp;
        if (chk_on) begin
            compare({test_name, " hsync"}, 32'(e_hs), 32'(o_hsync));
            compare({test_name, " vsync"}, 32'(e_vs), 32'(o_vsync));
            compare({test_name, " rgb"}, 32'(e_rgb), 32'(o_rgb));
        end
        if (chk_gp) compare({test_name, " gpout"}, 32'(e_gp), 32'(o_gpout));
        if (count_pulse && o_gpout[0]) pulse_cnt++;
    end

    task automatic step(int n);
        repeat (n) @(posedge clk);
        #1;     // Inputs change just after the edge
    endtask

    task automatic abort_run(string what);
        $display("ERROR: timeout, %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        step(1);
        while (!(m_h == 0 && m_v == 0) && n < WAIT_LIMIT) begin
            step(1);
            n++;
        end
        if (n >= WAIT_LIMIT) abort_run("raster never returned to the first pixel");
    endtask

    task automatic run_frames(int n);
        wait_frame_start();
        chk_on = 1'b1;
        chk_gp = 1'b1;
        step(n * H_TOT * V_TOT);
    endtask

    // MSB first with the serial clock toggling every 4 clocks
    task automatic send_frame(logic [16:0] bits, int nbits);
        int b;
        chk_on    = 1'b0;   // Registers change somewhere in here
        chk_gp    = 1'b0;
        i_reg_csb = 1'b0;
        step(4);
        for (b = nbits - 1; b >= 0; b--) begin
            i_reg_mosi = bits[b];
            step(4);
            i_reg_sclk = 1'b1;
            step(4);
            i_reg_sclk = 1'b0;
        end
        step(4);
        i_reg_csb  = 1'b1;
        i_reg_mosi = 1'b0;
        step(8);            // Update lands 3 to 4 clocks after csb rises
    endtask

    // Address 1 colours, address 2 control, others ignored
    task automatic model_frame(logic [15:0] f);
        if (f[15:12] == 4'd1) begin
            m_sky   = f[11:6];
            m_floor = f[5:0];
        end else if (f[15:12] == 4'd2) begin
            m_hor = int'(f[11:2]);
            m_ov  = f[1];
        end
    endtask

    task automatic pick_selects();
        logic [31:0] r;
        r = $random(seed);
        i_gpout0_sel = r[3:0];
        i_gpout1_sel = r[7:4];
        i_gpout2_sel = r[11:8];
    endtask

    initial begin : main_flow
        logic [31:0] r;
        logic [15:0] f;
        logic [3:0]  a;
        int          i;
        int          hor;
        int          base;
        seed = 32'hd3db;
        test_name = "reset";
        m_sky = 6'd0;
        m_floor = 6'd0;
        m_hor = 0;
        m_ov = 1'b0;
        rbzero_reset = 1'b1;
        i_reg_csb = 1'b1;
        i_reg_sclk = 1'b0;
        i_reg_mosi = 1'b0;
        i_reg_outs_enb = 1'b0;   // Registered mode through reset
        i_gpout0_sel = 4'd0;
        i_gpout1_sel = 4'd0;
        i_gpout2_sel = 4'd0;
        step(1);
        chk_on = 1'b1;
        chk_gp = 1'b1;
        step(4);
        rbzero_reset = 1'b0;
        step(2);                 // Registered copies just after release
        i_reg_outs_enb = 1'b1;
        test_name = "raster";
        run_frames(2);

        test_name = "frames";
        for (i = 0; i < 6; i++) begin
            r = $random(seed);
            f = {4'd1, r[5:0], r[11:6]};
            send_frame({1'b0, f}, 16);
            model_frame(f);
            hor = (i == 0) ? 0 : (i == 1) ? 15 : int'(r[31:16]) % 17;  // All floor, all sky
            f = {4'd2, 10'(hor), r[12], 1'b0};
            send_frame({1'b0, f}, 16);
            model_frame(f);
            run_frames(1);
        end

        // Each short or long frame would write inverted colours if accepted
        test_name = "bad";
        r = $random(seed);
        send_frame({2'b00, 3'b001, ~m_sky, ~m_floor}, 15);
        run_frames(1);
        send_frame({1'b0, 4'd1, ~m_sky, ~m_floor}, 17);
        run_frames(1);
        a = r[19:16];
        if (a == 4'd1 || a == 4'd2) a = 4'd7;
        send_frame({1'b0, a, r[31:20]}, 16);
        run_frames(1);

        test_name = "registered";
        i_reg_outs_enb = 1'b0;
        pick_selects();
        run_frames(1);

        test_name = "debug";
        for (i = 0; i < 24; i++) begin
            pick_selects();
            r = $random(seed);
            i_reg_outs_enb = r[0];
            step(37);
        end

        test_name = "pulse";
        i_reg_outs_enb = 1'b1;
        i_gpout0_sel = 4'd1;    // Frame pulse on channel 0
        count_pulse = 1'b1;
        base = pulse_cnt;
        r = $random(seed);
        f = {4'd1, r[5:0], r[11:6]};
        send_frame({1'b0, f}, 16);
        model_frame(f);
        compare("pulse good frame", 32'd1, 32'(pulse_cnt - base));
        base = pulse_cnt;
        send_frame({1'b0, 4'd9, r[23:12]}, 16);
        compare("pulse unused address", 32'd0, 32'(pulse_cnt - base));
        count_pulse = 1'b0;
        run_frames(1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/rbz_pkg.sv
rtl/reg_spi_rx.sv
rtl/vga_sync.sv
rtl/row_render.sv
rtl/gpout_bank.sv
rtl/vga_out_stage.sv
rtl/rbz_top.sv
bench/rbz_assertions.sv
bench/rbz_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the raster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rbz_tb -f all.f -o rbz_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/rbz_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi
